/* Makefile */
TOP = tb_dbg

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vlog.f --top-module $(TOP) -o V$(TOP)

run: build
	obj_dir/V$(TOP) > run.log 2>&1; cat run.log
	@if grep -qF '*** FAILED ***' run.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '*** PASSED ***' run.log; then echo "Simulation ended early"; exit 1; fi

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		-f vlog.f --top-module dbg_top

clean:
	rm -rf obj_dir run.log

.PHONY: all build run lint clean

/* design/dbg_engine.sv */
/*
  Debug packet engine. Decodes host packets, halts the CPU while
  active, and runs CPU memory and debug register traffic.
  Multi-byte fields arrive low byte first. A zero count ends the
  command at once. Replies stall on tx_full, memory traffic on a
  low cpumc_rdy; incoming bytes wait in the receiver meanwhile.
*/
`timescale 1ns/1ps

module dbg_engine
  import dbg_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     brk,             // CPU-initiated break
  input  byte_t    rx_data,
  input  logic     rx_empty,
  input  logic     parity_err,
  input  logic     tx_full,
  input  byte_t    cpu_din,
  input  logic     cpumc_rdy,       // Controller can take a request
  input  byte_t    cpu_dbgreg_in,   // Selected register, same cycle
  output logic     rd_en,
  output logic     tx_wr,
  output byte_t    tx_data,
  output logic     active,          // Holds the CPU
  output logic     cpu_req,
  output logic     cpu_r_nw,
  output addr_t    cpu_a,
  output byte_t    cpu_dout,
  output reg_sel_t cpu_dbgreg_sel,
  output byte_t    cpu_dbgreg_out,
  output logic     cpu_dbgreg_wr
);

  state_t     q_state, d_state;
  logic [1:0] q_hdr_cnt, d_hdr_cnt;  // Header byte position
  count_t     q_cnt, d_cnt;
  addr_t      q_addr, d_addr;
  reg_sel_t   q_sel, d_sel;
  err_t       q_err, d_err;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      q_state   <= S_DISABLED;
      q_hdr_cnt <= '0;
      q_err     <= '0;
    end
    else
    begin
      q_state   <= d_state;
      q_hdr_cnt <= d_hdr_cnt;
      q_err     <= d_err;
    end
  end

  // Loaded from the header before any use
  always_ff @(posedge clk)
  begin
    q_cnt  <= d_cnt;
    q_addr <= d_addr;
    q_sel  <= d_sel;
  end

  assign active         = (q_state != S_DISABLED);
  assign cpu_a          = q_addr;
  assign cpu_dout       = rx_data;  // Write data straight from the receiver
  assign cpu_dbgreg_out = rx_data;

  // Register read takes its select from the byte still in the receiver
  assign cpu_dbgreg_sel = (q_state == S_REG_RD) ? rx_data[3:0] : q_sel;

  always_comb
  begin
    d_state   = q_state;
    d_hdr_cnt = q_hdr_cnt;
    d_cnt     = q_cnt;
    d_addr    = q_addr;
    d_sel     = q_sel;
    d_err     = q_err;

    rd_en          = 1'b0;
    tx_wr          = 1'b0;
    tx_data        = rx_data;
    cpu_req        = 1'b0;
    cpu_r_nw       = 1'b1;
    cpu_dbgreg_wr  = 1'b0;

    if (parity_err)
      d_err[ERR_PARITY] = 1'b1;

    case (q_state)
      ////////////////////////////////////////////////////////////
      // Halted off: only break and query break are honored
      S_DISABLED:
        if (brk)
          d_state = S_DECODE;
        else if (!rx_empty)
        begin
          if (rx_data == OP_DBG_BRK)
          begin
            rd_en   = 1'b1;
            d_state = S_DECODE;
          end
          else if (rx_data == OP_QUERY_DBG_BRK)
          begin
            if (!tx_full)  // Leave opcode queued until reply fits
            begin
              rd_en   = 1'b1;
              tx_wr   = 1'b1;
              tx_data = 8'h00;  // Not in break
            end
          end
          else
            rd_en = 1'b1;  // Anything else is dropped
        end

      S_DECODE:
        if (!rx_empty && !(rx_data == OP_QUERY_DBG_BRK && tx_full))
        begin
          rd_en     = 1'b1;
          d_hdr_cnt = 2'd0;
          case (rx_data)
            OP_ECHO:
            begin
              d_state   = S_ECHO_HDR;
              d_hdr_cnt = 2'd2;  // Count only, no address
            end
            OP_CPU_MEM_RD:     d_state = S_MEM_RD_HDR;
            OP_CPU_MEM_WR:     d_state = S_MEM_WR_HDR;
            OP_DBG_BRK:        d_state = S_DECODE;
            OP_DBG_RUN:        d_state = S_DISABLED;
            OP_CPU_REG_RD:     d_state = S_REG_RD;
            OP_CPU_REG_WR:     d_state = S_REG_WR_SEL;
            OP_QUERY_ERR_CODE: d_state = S_QUERY_ERR;
            OP_QUERY_DBG_BRK:
            begin
              tx_wr   = 1'b1;
              tx_data = 8'h01;  // In break
            end
            default:           d_err[ERR_OPCODE] = 1'b1;
          endcase
        end

      ////////////////////////////////////////////////////////////
      // Shared header: ADDR_LO, ADDR_HI, CNT_LO, CNT_HI
      S_ECHO_HDR, S_MEM_RD_HDR, S_MEM_WR_HDR:
        if (!rx_empty)
        begin
          rd_en     = 1'b1;
          d_hdr_cnt = q_hdr_cnt + 2'd1;
          case (q_hdr_cnt)
            2'd0: d_addr[7:0]  = rx_data;
            2'd1: d_addr[15:8] = rx_data;
            2'd2: d_cnt[7:0]   = rx_data;
            default:
            begin
              d_cnt[15:8] = rx_data;
              if (d_cnt == '0)
                d_state = S_DECODE;
              else if (q_state == S_ECHO_HDR)
                d_state = S_ECHO_DATA;
              else if (q_state == S_MEM_RD_HDR)
                d_state = S_MEM_RD_REQ;
              else
                d_state = S_MEM_WR_DATA;
            end
          endcase
        end

      S_ECHO_DATA:
        if (!rx_empty && !tx_full)
        begin
          rd_en = 1'b1;
          tx_wr = 1'b1;  // tx_data already carries rx_data
          d_cnt = q_cnt - count_t'(1);
          if (d_cnt == '0)
            d_state = S_DECODE;
        end

      S_MEM_RD_REQ:
        if (cpumc_rdy)
        begin
          cpu_req = 1'b1;
          d_state = S_MEM_RD_WAIT;
        end

      S_MEM_RD_WAIT:
        if (cpumc_rdy && !tx_full)
        begin
          tx_wr   = 1'b1;
          tx_data = cpu_din;
          d_addr  = q_addr + addr_t'(1);
          d_cnt   = q_cnt - count_t'(1);
          d_state = (d_cnt == '0) ? S_DECODE : S_MEM_RD_REQ;
        end

      S_MEM_WR_DATA:
        if (!rx_empty && cpumc_rdy)
        begin
          rd_en    = 1'b1;
          cpu_req  = 1'b1;
          cpu_r_nw = 1'b0;
          d_addr   = q_addr + addr_t'(1);
          d_cnt    = q_cnt - count_t'(1);
          if (d_cnt == '0)
            d_state = S_MEM_WR_DONE;
        end

      S_MEM_WR_DONE:  // Last write must land first
        if (cpumc_rdy)
          d_state = S_DECODE;

      ////////////////////////////////////////////////////////////
      // Debug registers
      S_REG_RD:
        if (!rx_empty && !tx_full)
        begin
          rd_en          = 1'b1;
          tx_wr          = 1'b1;
          tx_data        = cpu_dbgreg_in;
          d_state        = S_DECODE;
        end

      S_REG_WR_SEL:
        if (!rx_empty)
        begin
          rd_en   = 1'b1;
          d_sel   = rx_data[3:0];
          d_state = S_REG_WR_DATA;
        end

      S_REG_WR_DATA:
        if (!rx_empty)
        begin
          rd_en         = 1'b1;
          cpu_dbgreg_wr = 1'b1;
          d_state       = S_DECODE;
        end

      S_QUERY_ERR:
        if (!tx_full)
        begin
          tx_wr   = 1'b1;
          tx_data = byte_t'(q_err);  // Flags in the low bits
          d_state = S_DECODE;
        end

      default: d_state = S_DISABLED;
    endcase
  end

  a_req_rdy: assert property (@(posedge clk) disable iff (rst) cpu_req |-> cpumc_rdy)
    else $error("Memory request while controller busy");

  a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
    !active |-> !(cpu_req || cpu_dbgreg_wr))
    else $error("CPU bus traffic while debug port inactive");

endmodule

/* design/dbg_pkg.sv */
/*
  Shared types and constants for the serial debug port.
  Line format is fixed at 8 data bits, odd parity, 1 stop bit.
  CLKS_PER_BIT is sized for simulation; a 50 MHz board at
  115200 baud needs 434 here.
*/
package dbg_pkg;

  typedef logic [7:0]  byte_t;     // Serial or bus data byte
  typedef logic [15:0] addr_t;     // CPU address
  typedef logic [15:0] count_t;    // Packet byte count
  typedef logic [3:0]  reg_sel_t;  // CPU debug register select
  typedef logic [1:0]  err_t;      // Sticky error flags, low bits of a reply

  // Bit positions in err_t
  localparam int ERR_PARITY = 0;
  localparam int ERR_OPCODE = 1;

  ////////////////////////////////////////////////////////////
  // Packet opcodes
  localparam byte_t OP_ECHO           = 8'h00;
  localparam byte_t OP_CPU_MEM_RD     = 8'h01;
  localparam byte_t OP_CPU_MEM_WR     = 8'h02;
  localparam byte_t OP_DBG_BRK        = 8'h03;
  localparam byte_t OP_DBG_RUN        = 8'h04;
  localparam byte_t OP_CPU_REG_RD     = 8'h05;
  localparam byte_t OP_CPU_REG_WR     = 8'h06;
  localparam byte_t OP_QUERY_DBG_BRK  = 8'h07;
  localparam byte_t OP_QUERY_ERR_CODE = 8'h08;

  ////////////////////////////////////////////////////////////
  // Serial timing
  localparam int CLKS_PER_BIT = 16;
  localparam int TICK_W       = $clog2(CLKS_PER_BIT);
  localparam int FRAME_BITS   = 11;  // Start, 8 data, parity, stop

  typedef logic [TICK_W-1:0] tick_t;     // Clocks within one bit
  typedef logic [3:0]        bit_idx_t;  // Bit position within a frame

  ////////////////////////////////////////////////////////////
  // Debug engine states
  typedef enum logic [4:0] {
    S_DISABLED, S_DECODE,
    S_ECHO_HDR, S_ECHO_DATA,
    S_MEM_RD_HDR, S_MEM_RD_REQ, S_MEM_RD_WAIT,
    S_MEM_WR_HDR, S_MEM_WR_DATA, S_MEM_WR_DONE,
    S_REG_RD,
    S_REG_WR_SEL, S_REG_WR_DATA,
    S_QUERY_ERR
  } state_t;

endpackage

/* design/dbg_top.sv */
/*
  Debug port top level. Receiver, transmitter and packet engine
  on one clock. The serial lines go straight to the pins with
  no extra buffering beyond one byte in each direction.
*/
`timescale 1ns/1ps

module dbg_top
  import dbg_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     rx,
  input  logic     brk,
  input  byte_t    cpu_din,
  input  byte_t    cpu_dbgreg_in,
  input  logic     cpumc_rdy,
  output logic     tx,
  output logic     active,
  output logic     cpu_req,
  output logic     cpu_r_nw,
  output addr_t    cpu_a,
  output byte_t    cpu_dout,
  output reg_sel_t cpu_dbgreg_sel,
  output byte_t    cpu_dbgreg_out,
  output logic     cpu_dbgreg_wr
);

  byte_t rx_data, tx_data;
  logic  rx_empty, parity_err, rd_en;  // Receiver side
  logic  tx_wr, tx_full;               // Transmitter side

  uart_rx u_rx (
    .clk(clk), .rst(rst), .rx(rx), .rd_en(rd_en),
    .rx_data(rx_data), .rx_empty(rx_empty), .parity_err(parity_err)
  );

  uart_tx u_tx (
    .clk(clk), .rst(rst), .tx_wr(tx_wr), .tx_data(tx_data),
    .tx(tx), .tx_full(tx_full)
  );

  dbg_engine u_engine (
    .clk(clk), .rst(rst), .brk(brk),
    .rx_data(rx_data), .rx_empty(rx_empty), .parity_err(parity_err),
    .tx_full(tx_full), .cpu_din(cpu_din), .cpumc_rdy(cpumc_rdy),
    .cpu_dbgreg_in(cpu_dbgreg_in),
    .rd_en(rd_en), .tx_wr(tx_wr), .tx_data(tx_data), .active(active),
    .cpu_req(cpu_req), .cpu_r_nw(cpu_r_nw), .cpu_a(cpu_a), .cpu_dout(cpu_dout),
    .cpu_dbgreg_sel(cpu_dbgreg_sel), .cpu_dbgreg_out(cpu_dbgreg_out),
    .cpu_dbgreg_wr(cpu_dbgreg_wr)
  );

endmodule

/* design/uart_rx.sv */
/*
  Serial receiver, 8 data bits, odd parity, 1 stop bit.
  Holds one byte only. A new good byte overwrites an unread
  one, so the host has to pace its traffic.
  Bad parity or a missing stop bit drops the byte and pulses
  parity_err for one cycle.
*/
`timescale 1ns/1ps

module uart_rx
  import dbg_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  rx,
  input  logic  rd_en,       // Pops the held byte
  output byte_t rx_data,
  output logic  rx_empty,
  output logic  parity_err   // One-cycle pulse per rejected frame
);

  logic       rx_meta, rx_sync, rx_prev;  // Synchronizer and edge history
  logic       busy;
  tick_t      tick;
  bit_idx_t   bit_idx;
  logic [8:0] shreg;                      // Data then parity, LSB first
  logic       mid_bit, stop_mid, frame_ok;

  assign mid_bit  = busy && (tick == '0);
  assign stop_mid = mid_bit && (bit_idx == bit_idx_t'(FRAME_BITS - 1));
  assign frame_ok = (^shreg) && rx_sync;  // Odd count of ones, stop high

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  ////////////////////////////////////////////////////////////
  // Bit timing, sampled in the middle of each bit
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy    <= 1'b0;
      tick    <= '0;
      bit_idx <= '0;
    end
    else if (!busy)
    begin
      if (rx_prev && !rx_sync)  // Falling edge, start bit
      begin
        busy    <= 1'b1;
        bit_idx <= '0;
        tick    <= tick_t'(CLKS_PER_BIT / 2 - 1);  // Half bit to the middle
      end
    end
    else if (tick != '0)
      tick <= tick - tick_t'(1);
    else
    begin
      tick    <= tick_t'(CLKS_PER_BIT - 1);
      bit_idx <= bit_idx + bit_idx_t'(1);
      if ((bit_idx == '0 && rx_sync) || stop_mid)
        busy <= 1'b0;  // Glitch on idle line, or frame done
    end
  end

  // Data and parity bits shift in from the top
  always_ff @(posedge clk)
    if (mid_bit && bit_idx != '0 && !stop_mid)
      shreg <= {rx_sync, shreg[8:1]};

  always_ff @(posedge clk)
    if (stop_mid && frame_ok)
      rx_data <= shreg[7:0];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rx_empty   <= 1'b1;
      parity_err <= 1'b0;
    end
    else
    begin
      parity_err <= stop_mid && !frame_ok;
      if (stop_mid && frame_ok)
        rx_empty <= 1'b0;  // New byte wins over a same-cycle pop
      else if (rd_en)
        rx_empty <= 1'b1;
    end
  end

  a_pop_held: assert property (@(posedge clk) disable iff (rst) rd_en |-> !rx_empty)
    else $error("uart_rx popped while empty");

endmodule

/* design/uart_tx.sv */
/*
  Serial transmitter, 8 data bits, odd parity, 1 stop bit.
  One holding register sits in front of the shifter. tx_full
  is high while it is occupied, and the writer must not strobe
  tx_wr then. A frame takes 11 bit times plus one idle cycle.
*/
`timescale 1ns/1ps

module uart_tx
  import dbg_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  tx_wr,
  input  byte_t tx_data,
  output logic  tx,
  output logic  tx_full
);

  byte_t                 hold;
  logic [FRAME_BITS-1:0] shreg;  // Bit 0 is the line
  logic                  busy;
  tick_t                 tick;
  bit_idx_t              bit_idx;
  logic                  load;

  assign load = tx_full && !busy;  // Holding register into idle shifter
  assign tx   = shreg[0];

  always_ff @(posedge clk)
    if (tx_wr)
      hold <= tx_data;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tx_full <= 1'b0;
      busy    <= 1'b0;
      tick    <= '0;
      bit_idx <= '0;
      shreg   <= '1;  // Line idles high
    end
    else
    begin
      if (tx_wr)
        tx_full <= 1'b1;
      else if (load)
        tx_full <= 1'b0;

      if (load)
      begin
        busy    <= 1'b1;
        tick    <= tick_t'(CLKS_PER_BIT - 1);
        bit_idx <= '0;
        shreg   <= {1'b1, ~^hold, hold, 1'b0};  // Stop, odd parity, data, start
      end
      else if (busy)
      begin
        if (tick != '0)
          tick <= tick - tick_t'(1);
        else
        begin
          tick    <= tick_t'(CLKS_PER_BIT - 1);
          bit_idx <= bit_idx + bit_idx_t'(1);
          shreg   <= {1'b1, shreg[FRAME_BITS-1:1]};  // Ones fill behind
          if (bit_idx == bit_idx_t'(FRAME_BITS - 1))
            busy <= 1'b0;
        end
      end
    end
  end

  a_no_overrun: assert property (@(posedge clk) disable iff (rst) tx_wr |-> !tx_full)
    else $error("uart_tx written while full");

endmodule

/* tests/tb_dbg.sv */
/*
  Testbench for the serial debug port.
  Host bytes are paced with a two-bit idle gap so that the
  one-byte receive buffer is never overrun during echo.
  Memory decodes the low address byte only, 256 entries, and
  stays busy for 0 to 3 cycles after each request.
*/
`timescale 1ns/1ps

module tb_dbg
  import dbg_pkg::*;
();

  localparam int GAP_CLKS       = 2 * CLKS_PER_BIT;  // Idle time after each host byte
  localparam int FRAME_CLKS     = FRAME_BITS * CLKS_PER_BIT;
  localparam int ACTIVE_TIMEOUT = 16;

  logic     clk;
  logic     rst       = 1'b1;
  logic     rx        = 1'b1;
  logic     brk       = 1'b0;
  byte_t    cpu_din   = '0;
  logic     cpumc_rdy = 1'b1;
  byte_t    cpu_dbgreg_in;
  logic     tx, active, cpu_req, cpu_r_nw, cpu_dbgreg_wr;
  addr_t    cpu_a;
  byte_t    cpu_dout, cpu_dbgreg_out;
  reg_sel_t cpu_dbgreg_sel;

  integer seed         = 13;
  int     checks       = 0;
  int     errors       = 0;
  int     frame_errors = 0;  // Counted by the tx monitor only
  int     timeouts     = 0;

  // Memory and register models
  byte_t      mem_init [256];  // Drawn from the seed at time 0
  byte_t      mem [256];
  logic [1:0] lat_tab [16];    // Busy cycles per request, used in turn
  logic [3:0] lat_idx;
  logic [1:0] lat_cnt;
  addr_t      req_a_q [$];     // Full cpu_a of every request, in order
  int         req_idx = 0;     // Next request address to check
  byte_t      regs [16];
  int         mem_i, reg_i;

  // Host side of the serial link
  logic        mon_busy;
  int          mon_tick, mon_bit;
  logic [10:0] mon_frame;
  byte_t       reply_q [$];  // Every byte seen on tx
  int          rd_idx = 0;   // Next reply to check
  byte_t       exp_q [$];

  dbg_top uut (
    .clk(clk), .rst(rst), .rx(rx), .brk(brk),
    .cpu_din(cpu_din), .cpu_dbgreg_in(cpu_dbgreg_in), .cpumc_rdy(cpumc_rdy),
    .tx(tx), .active(active), .cpu_req(cpu_req), .cpu_r_nw(cpu_r_nw),
    .cpu_a(cpu_a), .cpu_dout(cpu_dout), .cpu_dbgreg_sel(cpu_dbgreg_sel),
    .cpu_dbgreg_out(cpu_dbgreg_out), .cpu_dbgreg_wr(cpu_dbgreg_wr)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Power-up content of a debug register
  function automatic byte_t reg_init(input reg_sel_t s);
    return {s, ~s};
  endfunction

  task automatic check_byte(input byte_t got, input byte_t exp, input string what);
    checks++;
    assert (got == exp)
    else
    begin
      $display("FAILED at %0t: %s got %02h, expected %02h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Compares the next logged request address
  task automatic check_addr(input addr_t exp, input string what);
    checks++;
    if (req_idx >= req_a_q.size())
    begin
      $display("No memory request was seen for %s at %0t", what, $time);
      errors++;
    end
    else
    begin
      assert (req_a_q[req_idx] == exp)
      else
      begin
        $display("FAILED at %0t: %s got %04h, expected %04h", $time, what,
                 req_a_q[req_idx], exp);
        errors++;
      end
      req_idx++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Host transmitter, start, data LSB first, odd parity, stop
  task automatic send_byte(input byte_t b, input logic bad_parity);
    logic [10:0] frame;
    int          i;
    frame = {1'b1, (~^b) ^ bad_parity, b, 1'b0};
    for (i = 0; i < FRAME_BITS; i++)
    begin
      rx <= frame[i];
      repeat (CLKS_PER_BIT) @(posedge clk);
    end
    repeat (GAP_CLKS) @(posedge clk);
  endtask

  task automatic send_word(input logic [15:0] w);
    send_byte(w[7:0], 1'b0);  // Low byte first
    send_byte(w[15:8], 1'b0);
  endtask

  // Waits for every queued expectation, then compares in order
  task automatic check_replies(input string what);
    int cycles;
    int limit;
    cycles = 0;
    limit  = (exp_q.size() + 2) * 2 * FRAME_CLKS;
    while (reply_q.size() - rd_idx < exp_q.size() && cycles < limit)
    begin
      @(posedge clk);
      cycles++;
    end
    if (reply_q.size() - rd_idx < exp_q.size())
    begin
      $display("Timeout at %0t: %s got %0d of %0d reply bytes", $time, what,
               reply_q.size() - rd_idx, exp_q.size());
      timeouts++;
      rd_idx = reply_q.size();  // Resync with the line
    end
    else
    begin
      while (exp_q.size() > 0)
      begin
        check_byte(reply_q[rd_idx], exp_q.pop_front(), what);
        rd_idx++;
      end
    end
    exp_q.delete();
  endtask

  task automatic wait_active(input logic level, input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);  // Sample away from the driving edge
    while (active !== level && cycles < ACTIVE_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    checks++;
    assert (active === level)
    else
    begin
      $display("Timeout at %0t: active did not go %0b after %s", $time, level, what);
      timeouts++;
    end
    @(posedge clk);
  endtask

  task automatic store_frame(input logic [10:0] f);
    assert (!f[0] && f[10] && (^f[9:1]))
    else
    begin
      $display("Reply frame at %0t has a bad start, parity or stop bit", $time);
      frame_errors++;
    end
    reply_q.push_back(f[8:1]);
  endtask

  ////////////////////////////////////////////////////////////
  // Reply monitor, samples each tx bit near its middle
  always @(posedge clk)
  begin
    if (rst)
      mon_busy <= 1'b0;
    else if (!mon_busy)
    begin
      if (!tx)  // Start bit
      begin
        mon_busy <= 1'b1;
        mon_tick <= CLKS_PER_BIT / 2 - 1;
        mon_bit  <= 0;
      end
    end
    else if (mon_tick != 0)
      mon_tick <= mon_tick - 1;
    else
    begin
      mon_tick  <= CLKS_PER_BIT - 1;
      mon_bit   <= mon_bit + 1;
      mon_frame <= {tx, mon_frame[10:1]};
      if (mon_bit == FRAME_BITS - 1)  // Stop bit
      begin
        mon_busy <= 1'b0;
        store_frame({tx, mon_frame[10:1]});
      end
    end
  end

  // Memory controller, busy for a table-driven time per request
  always @(posedge clk)
  begin
    if (rst)
    begin
      for (mem_i = 0; mem_i < 256; mem_i++)
        mem[8'(mem_i)] <= mem_init[8'(mem_i)];
      cpumc_rdy <= 1'b1;
      lat_cnt   <= '0;
      lat_idx   <= '0;
    end
    else if (cpu_req)
    begin
      req_a_q.push_back(cpu_a);
      if (cpu_r_nw)
        cpu_din <= mem[cpu_a[7:0]];
      else
        mem[cpu_a[7:0]] <= cpu_dout;
      lat_cnt   <= lat_tab[lat_idx];
      lat_idx   <= lat_idx + 4'd1;
      cpumc_rdy <= (lat_tab[lat_idx] == 2'd0);
    end
    else if (lat_cnt != 2'd0)
    begin
      lat_cnt <= lat_cnt - 2'd1;
      if (lat_cnt == 2'd1)
        cpumc_rdy <= 1'b1;
    end
  end

  // Debug registers, read combinationally
  always @(posedge clk)
  begin
    if (rst)
      for (reg_i = 0; reg_i < 16; reg_i++)
        regs[4'(reg_i)] <= reg_init(4'(reg_i));
    else if (cpu_dbgreg_wr)
      regs[cpu_dbgreg_sel] <= cpu_dbgreg_out;
  end

  assign cpu_dbgreg_in = regs[cpu_dbgreg_sel];

  ////////////////////////////////////////////////////////////
  // Stimulus
  initial
  begin
    int    i;
    byte_t b;
    byte_t reg_val;
    byte_t wdata [$];
    addr_t addr;

    for (i = 0; i < 256; i++)
      mem_init[8'(i)] = byte_t'($random(seed));
    for (i = 0; i < 16; i++)
      lat_tab[4'(i)] = 2'($random(seed));
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    // Break by opcode and by pin, run, query break
    wait_active(1'b0, "reset");
    send_byte(OP_QUERY_DBG_BRK, 1'b0);
    exp_q.push_back(8'h00);
    check_replies("query break while running");
    send_byte(OP_DBG_BRK, 1'b0);
    wait_active(1'b1, "break opcode");
    send_byte(OP_QUERY_DBG_BRK, 1'b0);
    exp_q.push_back(8'h01);
    check_replies("query break in break");
    send_byte(OP_DBG_RUN, 1'b0);
    wait_active(1'b0, "run opcode");
    brk <= 1'b1;
    @(posedge clk);
    brk <= 1'b0;
    wait_active(1'b1, "brk pin");
    send_byte(OP_QUERY_ERR_CODE, 1'b0);
    exp_q.push_back(8'h00);  // No flags yet
    check_replies("error code after reset");

    // Echo of random bytes, then an empty echo
    send_byte(OP_ECHO, 1'b0);
    send_word(16'd8);
    for (i = 0; i < 8; i++)
    begin
      b = byte_t'($random(seed));
      exp_q.push_back(b);
      send_byte(b, 1'b0);
    end
    check_replies("echo");
    send_byte(OP_ECHO, 1'b0);
    send_word(16'd0);
    send_byte(OP_QUERY_DBG_BRK, 1'b0);
    exp_q.push_back(8'h01);
    check_replies("query break after empty echo");

    // Memory write then read back
    addr = 16'h52F4;
    send_byte(OP_CPU_MEM_WR, 1'b0);
    send_word(addr);
    send_word(16'd6);
    for (i = 0; i < 6; i++)
    begin
      b = byte_t'($random(seed));
      wdata.push_back(b);
      send_byte(b, 1'b0);
    end
    for (i = 0; i < 6; i++)
    begin
      check_byte(mem[8'(addr + i)], wdata[i], "memory model after write");
      check_addr(addr + addr_t'(i), "write address");
    end
    send_byte(OP_CPU_MEM_RD, 1'b0);
    send_word(addr);
    send_word(16'd6);
    for (i = 0; i < 6; i++)
      exp_q.push_back(wdata[i]);
    check_replies("memory read back");
    for (i = 0; i < 6; i++)
      check_addr(addr + addr_t'(i), "read address");

    // Register write and read, plus an untouched register
    reg_val = byte_t'($random(seed));
    send_byte(OP_CPU_REG_WR, 1'b0);
    send_byte(8'h05, 1'b0);
    send_byte(reg_val, 1'b0);
    send_byte(OP_CPU_REG_RD, 1'b0);
    send_byte(8'h05, 1'b0);
    exp_q.push_back(reg_val);
    check_replies("register read back");
    send_byte(OP_CPU_REG_RD, 1'b0);
    send_byte(8'h0A, 1'b0);
    exp_q.push_back(reg_init(4'hA));
    check_replies("unwritten register");

    // Sticky error flags
    send_byte(8'h09, 1'b0);  // Former PPU opcode
    send_byte(OP_QUERY_ERR_CODE, 1'b0);
    exp_q.push_back(byte_t'(1 << ERR_OPCODE));
    check_replies("error code after unknown opcode");
    send_byte(8'h55, 1'b1);  // Bad parity, byte dropped
    send_byte(OP_QUERY_ERR_CODE, 1'b0);
    exp_q.push_back(byte_t'((1 << ERR_OPCODE) | (1 << ERR_PARITY)));
    check_replies("error code after parity error");
    send_byte(OP_CPU_REG_RD, 1'b0);
    send_byte(8'h05, 1'b0);
    send_byte(OP_QUERY_ERR_CODE, 1'b0);
    exp_q.push_back(reg_val);
    exp_q.push_back(byte_t'((1 << ERR_OPCODE) | (1 << ERR_PARITY)));
    check_replies("flags kept after later command");

    repeat (2 * FRAME_CLKS) @(posedge clk);  // Let stray replies show up
    if (reply_q.size() != rd_idx)
    begin
      $display("%0d reply bytes arrived that no command asked for", reply_q.size() - rd_idx);
      errors++;
    end
    if (req_a_q.size() != req_idx)
    begin
      $display("%0d memory requests were issued that no command asked for",
               req_a_q.size() - req_idx);
      errors++;
    end

    $display("Checks: %0d, value errors: %0d, frame errors: %0d, timeouts: %0d",
             checks, errors, frame_errors, timeouts);
    if (errors + frame_errors + timeouts == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* vlog.f */
design/dbg_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/dbg_engine.sv
design/dbg_top.sv
tests/tb_dbg.sv
